// ==== common/video_pkg.sv ====
// ########################################
// video package: shared raster types
// coordinates, colours, sync bundle
// ########################################

package video_pkg;

    // screen coordinate width, enough for 1023
    localparam int cordw = 10;

    typedef logic [cordw-1:0] coord_t;  // unsigned screen position

    // 12-bit colour, 4 bits per channel as on the DVI pmod
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // raw timing levels, syncs are active low
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;     // high only in the visible area
    } video_sig_t;

    // everything that goes out on the pins in one cycle
    // msb first: hsync, vsync, de, then r/g/b
    typedef struct packed {
        video_sig_t sig;
        rgb_t       colour;
    } pixel_t;

    // what a pixel position falls on
    typedef enum logic [1:0] {
        region_blank      = 2'd0,  // outside the active area
        region_square     = 2'd1,  // inside the corner square
        region_background = 2'd2   // active but not square
    } region_t;

    // orange square
    localparam rgb_t colour_square = '{
        red:   4'hF,
        green: 4'h8,
        blue:  4'h0
    };

    // blue-ish backdrop
    localparam rgb_t colour_background = '{
        red:   4'h0,
        green: 4'h8,
        blue:  4'hF
    };

    // black, must be sent during blanking
    localparam rgb_t colour_blank = '{
        red:   4'h0,
        green: 4'h0,
        blue:  4'h0
    };

endpackage

// ==== display_timings/display_timings.sv ====
// ########################################
// display timings: raster position counters
// with active-low syncs and data enable
// ########################################

`timescale 1ns/1ps

module display_timings #(
    parameter int H_ACTIVE = 640,  // visible pixels per line
    parameter int H_FRONT  = 16,   // front porch in pixels
    parameter int H_SYNC   = 96,   // hsync pulse width
    parameter int H_BACK   = 48,   // back porch
    parameter int V_ACTIVE = 480,  // visible lines per frame
    parameter int V_FRONT  = 10,   // front porch in lines
    parameter int V_SYNC   = 2,    // vsync pulse in lines
    parameter int V_BACK   = 33    // back porch in lines
) (
    input  logic                   clk_pix,  // pixel clock
    input  logic                   rst_n,    // sync reset, active low
    output video_pkg::coord_t      sx,       // column, blanking included
    output video_pkg::coord_t      sy,       // line, blanking included
    output video_pkg::video_sig_t  sig       // syncs and enable for sx/sy
);

    import video_pkg::*;

    // full line and frame length
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // boundaries in coordinate width
    localparam coord_t H_ACT_END = coord_t'(H_ACTIVE);           // first blank column
    localparam coord_t HS_START  = coord_t'(H_ACTIVE + H_FRONT); // hsync goes low here
    localparam coord_t HS_END    = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam coord_t H_LAST    = coord_t'(H_TOTAL - 1);        // last column of a line

    localparam coord_t V_ACT_END = coord_t'(V_ACTIVE);           // first blank line
    localparam coord_t VS_START  = coord_t'(V_ACTIVE + V_FRONT); // vsync goes low here
    localparam coord_t VS_END    = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam coord_t V_LAST    = coord_t'(V_TOTAL - 1);        // last line of a frame

    logic line_end;   // sx on last column
    logic frame_end;  // last column of last line
    logic h_vis;      // sx inside visible columns
    logic v_vis;      // sy inside visible lines
    logic h_pulse;    // sx inside hsync window
    logic v_pulse;    // sy inside vsync window

    always_comb begin
        line_end  = (sx == H_LAST);
        frame_end = line_end && (sy == V_LAST);
    end

    // column counter, wraps every H_TOTAL clocks
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx <= '0;
        end else if (line_end) begin
            sx <= '0;
        end else begin
            sx <= sx + coord_t'(1);
        end
    end

    // line counter, steps once per line
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sy <= '0;
        end else if (frame_end) begin
            sy <= '0;  // back to top
        end else if (line_end) begin
            sy <= sy + coord_t'(1);
        end
    end

    // window decode from the live counters
    always_comb begin
        h_vis   = (sx < H_ACT_END);
        v_vis   = (sy < V_ACT_END);
        h_pulse = (sx >= HS_START) && (sx < HS_END);
        // whole lines, so vsync edges land on sx == 0
        v_pulse = (sy >= VS_START) && (sy < VS_END);
    end

    // zero latency, same cycle as sx/sy
    always_comb begin
        sig.hsync = ~h_pulse;        // negative polarity
        sig.vsync = ~v_pulse;        // negative polarity
        sig.de    = h_vis && v_vis;  // only where both are visible
    end

endmodule

// ==== source/square_painter.sv ====
// ########################################
// square painter: two-stage pixel pipeline
// ########################################

`timescale 1ns/1ps

module square_painter #(
    parameter int SQ_SIZE = 32  // square edge in pixels
) (
    input  logic                  clk_pix,  // pixel clock
    input  logic                  rst_n,    // sync reset, active low
    input  video_pkg::coord_t     sx,       // column from timings
    input  video_pkg::coord_t     sy,       // line from timings
    input  video_pkg::video_sig_t sig,      // syncs and enable for sx/sy
    output video_pkg::pixel_t     pix       // registered pin values
);

    import video_pkg::*;

    // square edge as a coordinate
    localparam coord_t SQ_LIMIT = coord_t'(SQ_SIZE);

    // idle levels: syncs released, enable off
    localparam video_sig_t SIG_IDLE = '{
        hsync: 1'b1,
        vsync: 1'b1,
        de:    1'b0
    };

    // full pixel with idle syncs and black
    localparam pixel_t PIX_IDLE = '{
        sig:    SIG_IDLE,
        colour: colour_blank
    };

    region_t    region_d;   // classification of current sx/sy
    region_t    region_q;   // stage 1 region
    video_sig_t sig_q;      // stage 1 syncs, aligned with region_q
    logic       in_square;  // both coords under SQ_SIZE
    rgb_t       colour_d;   // looked-up colour for region_q

    // stage 1 decode
    always_comb begin
        in_square = (sx < SQ_LIMIT) && (sy < SQ_LIMIT);
        if (!sig.de) begin
            region_d = region_blank;        // blanking wins over position
        end else if (in_square) begin
            region_d = region_square;
        end else begin
            region_d = region_background;
        end
    end

    // stage 1 registers, region and syncs move together
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            region_q <= region_blank;
            sig_q    <= SIG_IDLE;
        end else begin
            region_q <= region_d;
            sig_q    <= sig;
        end
    end

    // region to colour lookup
    always_comb begin
        case (region_q)
            region_square:     colour_d = colour_square;
            region_background: colour_d = colour_background;
            region_blank:      colour_d = colour_blank;
            default:           colour_d = colour_blank;  // unused code
        endcase
    end

    // stage 2, stands in for the I/O cell output registers
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            pix <= PIX_IDLE;
        end else begin
            pix.sig    <= sig_q;     // syncs delayed by 2 like colour
            pix.colour <= colour_d;
        end
    end

endmodule

// ==== source/square_display.sv ====
// ########################################
// square display: top level, timings plus
// painter driving 12-bit DVI pins
// ########################################

`timescale 1ns/1ps

module square_display #(
    parameter int H_ACTIVE = 640,  // 480p defaults
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33,
    parameter int SQ_SIZE  = 32    // corner square edge
) (
    input  logic       clk_pix,    // pixel clock, from PLL off-chip here
    input  logic       rst_n,      // sync reset, active low
    output logic       dvi_hsync,  // horizontal sync, active low
    output logic       dvi_vsync,  // vertical sync, active low
    output logic       dvi_de,     // data enable
    output logic [3:0] dvi_r,      // red channel
    output logic [3:0] dvi_g,      // green channel
    output logic [3:0] dvi_b       // blue channel
);

    import video_pkg::*;

    coord_t     sx;   // current column
    coord_t     sy;   // current line
    video_sig_t sig;  // raw syncs, same cycle as sx/sy
    pixel_t     pix;  // painted pixel, 2 clocks behind sx/sy

    // raster counters
    display_timings #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) timings0 (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .sig     (sig)
    );

    // colour pipeline
    square_painter #(
        .SQ_SIZE (SQ_SIZE)
    ) painter0 (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .sig     (sig),
        .pix     (pix)
    );

    // unpack onto the pins
    assign dvi_hsync = pix.sig.hsync;
    assign dvi_vsync = pix.sig.vsync;
    assign dvi_de    = pix.sig.de;
    assign dvi_r     = pix.colour.red;
    assign dvi_g     = pix.colour.green;
    assign dvi_b     = pix.colour.blue;

endmodule

// ==== verification/square_display_chk.sv ====
// ########################################
// square display checker: timing and colour
// assertions rebuilt from the DVI pins
// ########################################

`timescale 1ns/1ps

module square_display_chk #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33,
    parameter int SQ_SIZE  = 32
) (
    input logic       clk_pix,
    input logic       rst_n,
    input logic       dvi_hsync,
    input logic       dvi_vsync,
    input logic       dvi_de,
    input logic [3:0] dvi_r,
    input logic [3:0] dvi_g,
    input logic [3:0] dvi_b
);

    import video_pkg::*;

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int VS_CYCLES    = V_SYNC * H_TOTAL;   // vsync low time in clocks
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam logic [14:0] PINS_IDLE = {1'b1, 1'b1, 1'b0, 12'h000};  // syncs high, de low

    int fail_count = 0;  // read by the testbench

    logic [14:0] pins;       // all pins, msb is hsync
    logic [11:0] rgb;
    logic        de_q;
    logic        hs_q;
    logic        vs_q;
    logic        de_fall;
    logic        hs_fall;
    logic        hs_rise;
    logic        vs_fall;
    logic        vs_rise;
    logic        in_square;  // own position inside the corner square
    logic        de_armed;   // de fell, hsync fall still pending
    logic        hs_seen;
    logic        vs_seen;
    int          col_cnt;    // de high cycles in this run
    int          line_cnt;   // de runs since vsync rose
    int          de_gap;     // clocks since de fell
    int          hs_low;
    int          hs_gap;     // clocks since hsync fell
    int          vs_low;
    int          vs_gap;

    always_comb begin
        pins      = {dvi_hsync, dvi_vsync, dvi_de, dvi_r, dvi_g, dvi_b};
        rgb       = {dvi_r, dvi_g, dvi_b};
        de_fall   = de_q && !dvi_de;
        hs_fall   = hs_q && !dvi_hsync;
        hs_rise   = !hs_q && dvi_hsync;
        vs_fall   = vs_q && !dvi_vsync;
        vs_rise   = !vs_q && dvi_vsync;
        in_square = (col_cnt < SQ_SIZE) && (line_cnt < SQ_SIZE);
    end

    // position and interval counters
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            de_q     <= 1'b0;
            hs_q     <= 1'b1;  // idle syncs are high
            vs_q     <= 1'b1;
            col_cnt  <= 0;
            line_cnt <= 0;
            de_gap   <= 0;
            de_armed <= 1'b0;
            hs_low   <= 0;
            hs_gap   <= 0;
            hs_seen  <= 1'b0;
            vs_low   <= 0;
            vs_gap   <= 0;
            vs_seen  <= 1'b0;
        end else begin
            de_q <= dvi_de;
            hs_q <= dvi_hsync;
            vs_q <= dvi_vsync;
            if (dvi_de) begin
                col_cnt <= col_cnt + 1;
            end else if (de_fall) begin
                col_cnt <= 0;
            end
            if (vs_rise) begin
                line_cnt <= 0;              // new frame
            end else if (de_fall) begin
                line_cnt <= line_cnt + 1;
            end
            if (de_fall) begin
                de_gap   <= 1;
                de_armed <= 1'b1;
            end else begin
                de_gap <= de_gap + 1;
                if (hs_fall) begin
                    de_armed <= 1'b0;
                end
            end
            hs_low <= dvi_hsync ? 0 : hs_low + 1;
            vs_low <= dvi_vsync ? 0 : vs_low + 1;
            if (hs_fall) begin
                hs_gap  <= 1;
                hs_seen <= 1'b1;
            end else begin
                hs_gap <= hs_gap + 1;
            end
            if (vs_fall) begin
                vs_gap  <= 1;
                vs_seen <= 1'b1;
            end else begin
                vs_gap <= vs_gap + 1;
            end
        end
    end

    // reset and first cycle after it
    a_reset_hold: assert property (@(posedge clk_pix) !rst_n |=> pins == PINS_IDLE)
        else begin
            fail_count++;
            $error("error at %0t: pins expected %h actual %h", $time, PINS_IDLE, $sampled(pins));
        end
    a_reset_exit: assert property (@(posedge clk_pix) $rose(rst_n) |=> pins == PINS_IDLE)
        else begin
            fail_count++;
            $error("error at %0t: pins expected %h actual %h", $time, PINS_IDLE, $sampled(pins));
        end

    a_blank: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !dvi_de |-> rgb == colour_blank)
        else begin
            fail_count++;
            $error("error at %0t: dvi_rgb expected %h actual %h", $time, colour_blank,
                   $sampled(rgb));
        end
    a_square: assert property (@(posedge clk_pix) disable iff (!rst_n)
        dvi_de && in_square |-> rgb == colour_square)
        else begin
            fail_count++;
            $error("error at %0t: dvi_rgb expected %h actual %h", $time, colour_square,
                   $sampled(rgb));
        end
    a_backdrop: assert property (@(posedge clk_pix) disable iff (!rst_n)
        dvi_de && !in_square |-> rgb == colour_background)
        else begin
            fail_count++;
            $error("error at %0t: dvi_rgb expected %h actual %h", $time, colour_background,
                   $sampled(rgb));
        end

    // line timing
    a_de_run: assert property (@(posedge clk_pix) disable iff (!rst_n)
        de_fall |-> col_cnt == H_ACTIVE)
        else begin
            fail_count++;
            $error("error at %0t: dvi_de run expected %0d actual %0d", $time, H_ACTIVE,
                   $sampled(col_cnt));
        end
    a_hs_front: assert property (@(posedge clk_pix) disable iff (!rst_n)
        de_armed && hs_fall |-> de_gap == H_FRONT)
        else begin
            fail_count++;
            $error("error at %0t: dvi_hsync front porch expected %0d actual %0d", $time,
                   H_FRONT, $sampled(de_gap));
        end
    a_hs_late: assert property (@(posedge clk_pix) disable iff (!rst_n)
        de_armed && de_gap == H_FRONT |-> !dvi_hsync)
        else begin
            fail_count++;
            $error("error at %0t: dvi_hsync expected 0 actual 1", $time);
        end
    a_hs_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        hs_rise |-> hs_low == H_SYNC)
        else begin
            fail_count++;
            $error("error at %0t: dvi_hsync low time expected %0d actual %0d", $time,
                   H_SYNC, $sampled(hs_low));
        end
    a_hs_period: assert property (@(posedge clk_pix) disable iff (!rst_n)
        hs_seen && hs_fall |-> hs_gap == H_TOTAL)
        else begin
            fail_count++;
            $error("error at %0t: dvi_hsync period expected %0d actual %0d", $time,
                   H_TOTAL, $sampled(hs_gap));
        end

    // frame timing
    a_de_lines: assert property (@(posedge clk_pix) disable iff (!rst_n)
        vs_fall |-> line_cnt == V_ACTIVE)
        else begin
            fail_count++;
            $error("error at %0t: dvi_de runs per frame expected %0d actual %0d", $time,
                   V_ACTIVE, $sampled(line_cnt));
        end
    a_vs_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        vs_rise |-> vs_low == VS_CYCLES)
        else begin
            fail_count++;
            $error("error at %0t: dvi_vsync low time expected %0d actual %0d", $time,
                   VS_CYCLES, $sampled(vs_low));
        end
    a_vs_period: assert property (@(posedge clk_pix) disable iff (!rst_n)
        vs_seen && vs_fall |-> vs_gap == FRAME_CYCLES)
        else begin
            fail_count++;
            $error("error at %0t: dvi_vsync period expected %0d actual %0d", $time,
                   FRAME_CYCLES, $sampled(vs_gap));
        end

endmodule

// attached to every square_display, sees only its ports
bind square_display square_display_chk #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK),
    .SQ_SIZE  (SQ_SIZE)
) chk0 (
    .clk_pix   (clk_pix),
    .rst_n     (rst_n),
    .dvi_hsync (dvi_hsync),
    .dvi_vsync (dvi_vsync),
    .dvi_de    (dvi_de),
    .dvi_r     (dvi_r),
    .dvi_g     (dvi_g),
    .dvi_b     (dvi_b)
);

// ==== verification/tb_square_display.sv ====
// ########################################
// square display testbench: reduced frame,
// clock, reset and watchdog
// ########################################

`timescale 1ns/1ps

module tb_square_display;

    // small frame so a few frames run quickly
    localparam int H_ACTIVE = 40;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 6;
    localparam int H_BACK   = 6;
    localparam int V_ACTIVE = 20;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 3;
    localparam int SQ_SIZE  = 8;

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 56
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 27
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int CLK_PERIOD   = 8;   // ns
    localparam int RUN_FRAMES   = 3;
    localparam int LIMIT_NS     = (4 * FRAME_CYCLES + 100) * CLK_PERIOD;  // 4 frames + margin

    logic       clk_pix;
    logic       rst_n;
    logic       dvi_hsync;
    logic       dvi_vsync;
    logic       dvi_de;
    logic [3:0] dvi_r;
    logic [3:0] dvi_g;
    logic [3:0] dvi_b;

    square_display #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK),
        .SQ_SIZE  (SQ_SIZE)
    ) dut0 (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .dvi_hsync (dvi_hsync),
        .dvi_vsync (dvi_vsync),
        .dvi_de    (dvi_de),
        .dvi_r     (dvi_r),
        .dvi_g     (dvi_g),
        .dvi_b     (dvi_b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pix = ~clk_pix;
    end

    // block until n vsync falling edges have gone by
    task automatic wait_vsync_falls(input int count);
        int   seen;
        logic vs_prev;
        seen    = 0;
        vs_prev = dvi_vsync;
        while (seen < count) begin
            @(negedge clk_pix);
            if (vs_prev && !dvi_vsync) begin
                seen++;
            end
            vs_prev = dvi_vsync;
        end
    endtask

    // lets the vsync width check see the rising edge
    task automatic wait_vsync_release;
        while (!dvi_vsync) begin
            @(negedge clk_pix);
        end
    endtask

    // any bound assertion failure ends the run
    always @(negedge clk_pix) begin
        if (dut0.chk0.fail_count != 0) begin
            $display("TEST FAIL");
            $fatal(1, "checker assertion failed");
        end
    end

    initial begin
        #(LIMIT_NS);
        $display("run timed out before the frames completed");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n = 1'b0;                     // 2 rising edges in reset
        repeat (2) @(negedge clk_pix);
        rst_n = 1'b1;
        wait_vsync_falls(RUN_FRAMES);
        wait_vsync_release();
        repeat (2) @(negedge clk_pix);    // let the last checks settle
        if (dut0.chk0.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "checker reported failures");
        end
    end

endmodule

// ==== square_display.f ====
common/video_pkg.sv
display_timings/display_timings.sv
source/square_painter.sv
source/square_display.sv
verification/square_display_chk.sv
verification/tb_square_display.sv

// ==== Makefile ====
VERILATOR = verilator
TOP       = tb_square_display
FILELIST  = square_display.f
BUILD_DIR = obj_dir
VFLAGS    = --binary --timing --assert -j 0
RUN_FLAGS = +verilator+error+limit+100
LOG       = sim.log
FAIL_MSG  = TEST FAIL
PASS_MSG  = TEST PASS

BIN  = $(BUILD_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
